// ==== common/conv_settings.svh ====
`ifndef CONV_SETTINGS_SVH
`define CONV_SETTINGS_SVH

// array rows, also words per input vector
`define ARRAY_HEIGHT 4
// array columns, also words per output vector
`define ARRAY_WIDTH 4

`define IFMAP_WIDTH 16
`define WEIGHT_WIDTH 16
`define OFMAP_WIDTH 32

// vectors per bank
`define BANK_DEPTH 8

`endif

// ==== common/conv_pkg.sv ====
`default_nettype none

`include "conv_settings.svh"

package conv_pkg;

  typedef logic signed [`IFMAP_WIDTH-1:0] ifmap_t;
  typedef logic signed [`WEIGHT_WIDTH-1:0] weight_t;
  typedef logic signed [`OFMAP_WIDTH-1:0] psum_t;

  // element r feeds array row r
  typedef ifmap_t [`ARRAY_HEIGHT-1:0] ifmap_vec_t;

  // element c is output column c
  typedef psum_t [`ARRAY_WIDTH-1:0] psum_vec_t;

endpackage

`default_nettype wire

// ==== source/skew_line.sv ====
`timescale 1ns/1ps
`default_nettype none

module skew_line #(
  parameter type elem_t  = logic [15:0],
  parameter int  LANES   = 4,
  parameter bit  REVERSE = 1'b0
) (
  input  wire                      clk,
  input  wire                      rst_n,
  input  wire  elem_t [LANES-1:0]  din,
  output wire  elem_t [LANES-1:0]  dout
);

  for (genvar i = 0; i < LANES; i++) begin : g_lane
    // triangular delay, longest lane first when reversed
    localparam int DEPTH = REVERSE ? LANES - 1 - i : i;

    if (DEPTH == 0) begin : g_pass
      assign dout[i] = din[i];
    end else begin : g_delay
      elem_t chain [DEPTH];

      always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
          for (int k = 0; k < DEPTH; k++) begin
            chain[k] <= '0;
          end
        end else begin
          chain[0] <= din[i];
          for (int k = 1; k < DEPTH; k++) begin
            chain[k] <= chain[k-1];
          end
        end
      end

      assign dout[i] = chain[DEPTH-1];
    end
  end

endmodule

`default_nettype wire

// ==== systolic_array/pe.sv ====
`timescale 1ns/1ps
`default_nettype none

module pe (
  input  wire                        clk,
  input  wire                        rst_n,
  input  wire                        weight_load,
  input  wire  conv_pkg::weight_t    weight_in,
  input  wire  conv_pkg::ifmap_t     ifmap_in,
  input  wire  conv_pkg::psum_t      psum_in,
  output conv_pkg::ifmap_t           ifmap_out,
  output conv_pkg::psum_t            psum_out
);

  import conv_pkg::*;

  weight_t weight_q;   // stationary weight
  psum_t   prod;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      weight_q <= '0;
    end else if (weight_load) begin
      weight_q <= weight_in;
    end
  end

  // operands sign extend to 32 bits before the multiply
  always_comb begin
    prod = ifmap_in * weight_q;
  end

  always_ff @(posedge clk) begin
    ifmap_out <= ifmap_in;          // on to the right
    psum_out  <= psum_in + prod;    // down, wraps in 32 bits
  end

endmodule

`default_nettype wire

// ==== systolic_array/systolic_array.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "conv_settings.svh"

module systolic_array (
  input  wire                           clk,
  input  wire                           rst_n,
  input  wire  conv_pkg::weight_t       weights_dat,
  input  wire                           weights_vld,
  input  wire  conv_pkg::ifmap_vec_t    rd_vec,
  input  wire                           rd_vld,
  output conv_pkg::psum_vec_t           ofmap_dat,
  output logic                          ofmap_vld
);

  import conv_pkg::*;

  localparam int H     = `ARRAY_HEIGHT;
  localparam int W     = `ARRAY_WIDTH;
  localparam int LAT   = H + W;
  localparam int IDX_W = $clog2(H * W);
  localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(H * W - 1);

  logic [IDX_W-1:0] widx;      // weight word index, row major
  logic [LAT-1:0]   vld_pipe;
  ifmap_vec_t       x_skew;
  ifmap_t           h_bus [H][W];     // ifmap into each PE from the left
  psum_t            v_bus [H+1][W];   // psum into each row from above
  psum_vec_t        col_sum;
  psum_vec_t        col_align;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      widx <= '0;
    end else if (weights_vld) begin
      widx <= (widx == LAST_IDX) ? '0 : widx + 1'b1;
    end
  end

  skew_line #(.elem_t(ifmap_t), .LANES(H), .REVERSE(1'b0)) u_in_skew (
    .clk   (clk),
    .rst_n (rst_n),
    .din   (rd_vec),
    .dout  (x_skew)
  );

  for (genvar r = 0; r < H; r++) begin : g_row
    assign h_bus[r][0] = x_skew[r];

    for (genvar c = 0; c < W; c++) begin : g_col
      if (c < W - 1) begin : g_inner
        pe u_pe (
          .clk         (clk),
          .rst_n       (rst_n),
          .weight_load (weights_vld && (widx == IDX_W'(r * W + c))),
          .weight_in   (weights_dat),
          .ifmap_in    (h_bus[r][c]),
          .psum_in     (v_bus[r][c]),
          .ifmap_out   (h_bus[r][c+1]),
          .psum_out    (v_bus[r+1][c])
        );
      end else begin : g_edge
        pe u_pe (
          .clk         (clk),
          .rst_n       (rst_n),
          .weight_load (weights_vld && (widx == IDX_W'(r * W + c))),
          .weight_in   (weights_dat),
          .ifmap_in    (h_bus[r][c]),
          .psum_in     (v_bus[r][c]),
          .ifmap_out   (),   // right edge
          .psum_out    (v_bus[r+1][c])
        );
      end
    end
  end

  for (genvar c = 0; c < W; c++) begin : g_colsum
    assign v_bus[0][c] = '0;        // top row starts from zero
    assign col_sum[c]  = v_bus[H][c];
  end

  // column c leaves the array c cycles late, so delay it W-1-c
  skew_line #(.elem_t(psum_t), .LANES(W), .REVERSE(1'b1)) u_out_deskew (
    .clk   (clk),
    .rst_n (rst_n),
    .din   (col_sum),
    .dout  (col_align)
  );

  always_ff @(posedge clk) begin
    ofmap_dat <= col_align;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_pipe <= '0;
    end else begin
      vld_pipe <= {vld_pipe[LAT-2:0], rd_vld};
    end
  end

  assign ofmap_vld = vld_pipe[LAT-1];

  // a weight change mid flight would mix two weight sets in one result
  a_weights_idle: assert property (@(posedge clk) disable iff (!rst_n)
    weights_vld |-> (vld_pipe == '0))
    else $error("systolic_array: weights_vld while vectors are in flight");

endmodule

`default_nettype wire

// ==== source/ifmap_packer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "conv_settings.svh"

module ifmap_packer (
  input  wire                           clk,
  input  wire                           rst_n,
  input  wire  conv_pkg::ifmap_t        ifmap_dat,
  input  wire                           ifmap_vld,
  output conv_pkg::ifmap_vec_t          vec,
  output logic                          vec_vld
);

  localparam int CNT_W = $clog2(`ARRAY_HEIGHT);
  localparam logic [CNT_W-1:0] LAST_ROW = CNT_W'(`ARRAY_HEIGHT - 1);

  logic [CNT_W-1:0] cnt;   // row slot of the next word
  logic             last;

  assign last = ifmap_vld && (cnt == LAST_ROW);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt     <= '0;
      vec_vld <= 1'b0;
    end else begin
      vec_vld <= last;   // vector complete after the last word
      if (last) begin
        cnt <= '0;
      end else if (ifmap_vld) begin
        cnt <= cnt + 1'b1;
      end
    end
  end

  // word k of a group lands in row k
  always_ff @(posedge clk) begin
    if (ifmap_vld) begin
      vec[cnt] <= ifmap_dat;
    end
  end

endmodule

`default_nettype wire

// ==== source/double_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "conv_settings.svh"

module double_buffer (
  input  wire                           clk,
  input  wire                           rst_n,
  input  wire  conv_pkg::ifmap_vec_t    vec,
  input  wire                           vec_vld,
  output conv_pkg::ifmap_vec_t          rd_vec,
  output logic                          rd_vld
);

  import conv_pkg::*;

  localparam int AW = $clog2(`BANK_DEPTH);
  localparam logic [AW-1:0] LAST_ADDR = AW'(`BANK_DEPTH - 1);

  ifmap_vec_t    mem [2][`BANK_DEPTH];
  logic [AW-1:0] wr_addr;
  logic          wr_bank;
  logic [AW-1:0] rd_addr;   // drain counter
  logic          rd_bank;
  logic [1:0]    full;
  logic          fill;
  logic          rd_en;
  logic          drained;

  assign fill    = vec_vld && (wr_addr == LAST_ADDR);
  assign rd_en   = full[rd_bank];   // a full bank drains one vector per cycle
  assign drained = rd_en && (rd_addr == LAST_ADDR);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_addr <= '0;
      wr_bank <= 1'b0;
    end else if (vec_vld) begin
      if (fill) begin
        wr_addr <= '0;
        wr_bank <= ~wr_bank;   // switch to the other bank
      end else begin
        wr_addr <= wr_addr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_addr <= '0;
      rd_bank <= 1'b0;
      rd_vld  <= 1'b0;
    end else begin
      rd_vld <= rd_en;
      if (drained) begin
        rd_addr <= '0;
        rd_bank <= ~rd_bank;
      end else if (rd_en) begin
        rd_addr <= rd_addr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      full <= '0;
    end else begin
      if (drained) full[rd_bank] <= 1'b0;
      if (fill) full[wr_bank] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (vec_vld) begin
      mem[wr_bank][wr_addr] <= vec;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_vec <= mem[rd_bank][rd_addr];   // registered read
    end
  end

  // drain must finish before the bank comes round again
  a_no_write_full: assert property (@(posedge clk) disable iff (!rst_n)
    vec_vld |-> !full[wr_bank])
    else $error("double_buffer: write into bank %0d while it is still full", wr_bank);

  a_burst_len: assert property (@(posedge clk) disable iff (!rst_n)
    rd_vld [*`BANK_DEPTH] |=> !rd_vld)
    else $error("double_buffer: rd_vld high longer than one bank");

endmodule

`default_nettype wire

// ==== source/conv_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module conv_core (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire  conv_pkg::ifmap_t       ifmap_dat,
  input  wire                          ifmap_vld,
  input  wire  conv_pkg::weight_t      weights_dat,
  input  wire                          weights_vld,
  output wire  conv_pkg::psum_vec_t    ofmap_dat,
  output wire                          ofmap_vld
);

  import conv_pkg::*;

  ifmap_vec_t vec;      // packed vector from the packer
  logic       vec_vld;
  ifmap_vec_t rd_vec;   // drained vector into the array
  logic       rd_vld;

  ifmap_packer u_packer (
    .clk       (clk),
    .rst_n     (rst_n),
    .ifmap_dat (ifmap_dat),
    .ifmap_vld (ifmap_vld),
    .vec       (vec),
    .vec_vld   (vec_vld)
  );

  // two banks, a full one drains while the other fills
  double_buffer u_ifmap_buf (
    .clk     (clk),
    .rst_n   (rst_n),
    .vec     (vec),
    .vec_vld (vec_vld),
    .rd_vec  (rd_vec),
    .rd_vld  (rd_vld)
  );

  systolic_array u_sys_arr (
    .clk         (clk),
    .rst_n       (rst_n),
    .weights_dat (weights_dat),
    .weights_vld (weights_vld),
    .rd_vec      (rd_vec),
    .rd_vld      (rd_vld),
    .ofmap_dat   (ofmap_dat),
    .ofmap_vld   (ofmap_vld)
  );

endmodule

`default_nettype wire

// ==== test/tb_conv_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "conv_settings.svh"

module tb_conv_core;

  import conv_pkg::*;

  localparam int H              = `ARRAY_HEIGHT;
  localparam int W              = `ARRAY_WIDTH;
  localparam int BANKS          = 4;
  localparam int WORDS_PER_BANK = H * `BANK_DEPTH;
  localparam int TOTAL_WORDS    = BANKS * WORDS_PER_BANK;
  localparam int TOTAL_WEIGHTS  = 2 * H * W;
  localparam int TIMEOUT_CYCLES = TOTAL_WORDS * 4 + TOTAL_WEIGHTS + 100;

  logic      clk;
  logic      rst_n;
  ifmap_t    ifmap_dat;
  logic      ifmap_vld;
  weight_t   weights_dat;
  logic      weights_vld;
  psum_vec_t ofmap_dat;
  logic      ofmap_vld;

  int        w_model [H][W];   // weights as the DUT should hold them
  int        w_idx;
  ifmap_t    cur_vec [H];
  int        word_pos;
  int        words_sent;
  psum_vec_t exp_q [$];
  psum_vec_t exp_head;
  logic      exp_empty = 1'b1;
  int        seen = 0;
  int        bursts = 0;
  int        vld_run;         // consecutive ofmap_vld cycles so far
  logic      vld_prev = 1'b0;

  conv_core dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .ifmap_dat   (ifmap_dat),
    .ifmap_vld   (ifmap_vld),
    .weights_dat (weights_dat),
    .weights_vld (weights_vld),
    .ofmap_dat   (ofmap_dat),
    .ofmap_vld   (ofmap_vld)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1);
  endtask

  // y[c] = sum over r of x[r] * w[r][c], kept to 32 bits
  function automatic psum_vec_t expected_out(input ifmap_t x [H]);
    psum_vec_t y;
    longint    acc;
    for (int c = 0; c < W; c++) begin
      acc = 0;
      for (int r = 0; r < H; r++) begin
        acc += longint'(x[r]) * longint'(w_model[r][c]);
      end
      y[c] = acc[31:0];
    end
    return y;
  endfunction

  function automatic void refresh_head();
    exp_empty = (exp_q.size() == 0);
    if (!exp_empty) begin
      exp_head = exp_q[0];
    end
  endfunction

  task automatic send_word(input ifmap_t w, input int gap);
    ifmap_dat = w;
    ifmap_vld = 1'b1;
    cur_vec[word_pos] = w;
    words_sent++;
    if (word_pos == H - 1) begin   // vector complete
      exp_q.push_back(expected_out(cur_vec));
      refresh_head();
      word_pos = 0;
    end else begin
      word_pos++;
    end
    @(posedge clk);
    #1;
    ifmap_vld = 1'b0;
    repeat (gap) begin
      @(posedge clk);
      #1;
    end
  endtask

  // extremes: vector 0 all most negative, vector 1 all most positive
  task automatic send_bank(input bit extremes);
    ifmap_t x;
    for (int v = 0; v < `BANK_DEPTH; v++) begin
      for (int r = 0; r < H; r++) begin
        x = ifmap_t'($urandom());
        if (extremes && v == 0) begin
          x = 16'sh8000;
        end else if (extremes && v == 1) begin
          x = 16'sh7fff;
        end
        send_word(x, $urandom_range(3, 0));
      end
    end
  endtask

  task automatic load_weights(input bit extremes);
    weight_t w;
    for (int n = 0; n < H * W; n++) begin
      w = weight_t'($urandom());
      if (extremes && (n % W == 0)) begin
        w = 16'sh8000;   // col 0 with -32768 inputs sums to 2^32
      end else if (extremes && (n % W == 1)) begin
        w = 16'sh7fff;
      end
      weights_dat = w;
      weights_vld = 1'b1;
      w_model[w_idx / W][w_idx % W] = w;
      w_idx = (w_idx + 1) % (H * W);
      @(posedge clk);
      #1;
    end
    weights_vld = 1'b0;
  endtask

  task automatic wait_idle();
    while (exp_q.size() != 0) begin
      @(posedge clk);
      #1;
    end
    repeat (2) begin
      @(posedge clk);
      #1;
    end
  endtask

  // output monitor, pops the reference queue
  always @(posedge clk) begin
    if (rst_n && ofmap_vld) begin
      if (!vld_prev) begin
        bursts++;
      end
      if (exp_q.size() != 0) begin
        void'(exp_q.pop_front());
        seen++;
        refresh_head();
      end
    end
    vld_prev = ofmap_vld;
  end

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_run <= 0;
    end else if (ofmap_vld) begin
      vld_run <= vld_run + 1;
    end else begin
      vld_run <= 0;
    end
  end

  a_quiet_before_fill: assert property (@(posedge clk) disable iff (!rst_n)
    ofmap_vld |-> (words_sent >= WORDS_PER_BANK))
    else fail_run("ofmap_vld went high before the first bank was filled");

  a_output_expected: assert property (@(posedge clk) disable iff (!rst_n)
    ofmap_vld |-> !exp_empty)
    else fail_run("ofmap_vld went high with no output expected");

  a_output_value: assert property (@(posedge clk) disable iff (!rst_n)
    (ofmap_vld && !exp_empty) |-> (ofmap_dat == exp_head))
    else fail_run($sformatf("error: ofmap_dat expected %h actual %h",
                            $sampled(exp_head), $sampled(ofmap_dat)));

  a_burst_long: assert property (@(posedge clk) disable iff (!rst_n)
    ofmap_vld |-> (vld_run < `BANK_DEPTH))
    else fail_run("ofmap_vld burst lasted longer than one bank");

  a_burst_short: assert property (@(posedge clk) disable iff (!rst_n)
    (!ofmap_vld && vld_run != 0) |-> (vld_run == `BANK_DEPTH))
    else fail_run("ofmap_vld burst ended before a whole bank came out");

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    fail_run($sformatf("timeout: run not finished after %0d cycles", TIMEOUT_CYCLES));
  end

  initial begin
    void'($urandom(5));
    rst_n       = 1'b0;
    ifmap_dat   = '0;
    ifmap_vld   = 1'b0;
    weights_dat = '0;
    weights_vld = 1'b0;
    w_idx       = 0;
    word_pos    = 0;
    words_sent  = 0;
    exp_head    = '0;
    for (int r = 0; r < H; r++) begin
      for (int c = 0; c < W; c++) begin
        w_model[r][c] = 0;
      end
    end
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;

    load_weights(1'b0);
    // three banks back to back
    for (int b = 0; b < 3; b++) begin
      send_bank(1'b0);
    end
    wait_idle();

    // new weight set while idle, then a bank that wraps
    load_weights(1'b1);
    send_bank(1'b1);
    wait_idle();

    if (seen == BANKS * `BANK_DEPTH && bursts == BANKS && exp_q.size() == 0) begin
      $display("Everything OK");
      $finish;
    end else begin
      fail_run($sformatf("run ended with %0d of %0d outputs in %0d bursts",
                         seen, BANKS * `BANK_DEPTH, bursts));
    end
  end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+common
common/conv_pkg.sv
source/skew_line.sv
systolic_array/pe.sv
systolic_array/systolic_array.sv
source/ifmap_packer.sv
source/double_buffer.sv
source/conv_core.sv
test/tb_conv_core.sv
